// ==== verilog.f ====
rtl/soc_bus_pkg.sv
rtl/req_decoder.sv
rtl/target_port.sv
rtl/resp_router.sv
rtl/soc_bus.sv
verif/tb_clock_gen.sv
verif/tb_target_model.sv
verif/tb_soc_bus.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_soc_bus
LOG        ?= sim.log
SEED_FLAGS ?= +verilator+seed+1
OBJ_DIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
	  -f verilog.f --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SEED_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "All tests passed" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_soc_bus.sv ====
// testbench for soc_bus with reset, decode, default port, data path,
// contention and concurrent traffic against a reference model
`timescale 1ns/1ps

module tb_soc_bus import soc_bus_pkg::*; ();

  localparam int N_DECODE   = 20;
  localparam int N_DATA     = 16;  // write/read pairs
  localparam int N_ROUNDS   = 4;
  localparam int N_STREAM   = 10;  // per initiator in the concurrency test
  localparam int N_TXN      = N_DECODE + N_INIT + 2 * N_DATA + (N_ROUNDS + N_STREAM) * N_INIT;
  localparam int TIMEOUT_NS = N_TXN * 40 * 4;

  logic                clk, rst_n;
  logic [N_INIT-1:0]   init_req, init_we, init_gnt, init_rsp_valid;
  addr_t               init_addr [N_INIT];
  data_t               init_wdata [N_INIT];
  data_t               init_rdata [N_INIT];
  logic [N_TGT-1:0]    tgt_req, tgt_we, tgt_rsp_valid;
  addr_t               tgt_addr [N_TGT];
  data_t               tgt_wdata [N_TGT];
  data_t               tgt_rdata [N_TGT];
  init_idx_t           tgt_src [N_TGT];
  init_idx_t           tgt_rsp_src [N_TGT];

  data_t       ref_mem [N_TGT][64];
  int          ref_ptr [N_TGT];   // round-robin start per target
  bit          busy [N_TGT];      // open transaction at the target
  int          pending [N_INIT];  // target being requested or -1
  int          max_busy = 0;
  addr_t       st_addr [N_INIT][N_STREAM];
  logic        st_we [N_INIT][N_STREAM];
  data_t       st_data [N_INIT][N_STREAM];
  addr_t       unmapped [N_INIT] = '{32'h0000_1000, 32'h8000_0000, 32'h1030_0000, 32'h1C01_0000};
  logic [31:0] seed = 32'h5a89;
  int          n_err = 0;
  int          n_pass = 0;
  int          n_fail = 0;

  tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));
  soc_bus dut (.*);
  tb_target_model u_tgt (.*);

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed ^ (seed >> 15);  // fold high bits into the weak low ones
  endfunction

  function automatic int decode_ref(input addr_t a);
    addr_t lo;
    for (int c = 0; c < N_CLUSTERS; c++) begin
      lo = CLUSTER_BASE + addr_t'(c) * CLUSTER_STRIDE;
      if (a >= lo && a < lo + CLUSTER_SIZE) return c;
    end
    if (a >= L2_BASE && a < L2_BASE + L2_SIZE) return int'(IDX_L2);
    if (a >= DEBUG_BASE && a < DEBUG_BASE + DEBUG_SIZE) return int'(IDX_DEBUG);
    return int'(IDX_EXT);
  endfunction

  // word-aligned address in a region where 3 means unmapped
  function automatic addr_t rand_addr(input int region);
    logic [31:0] r;
    r = next_rand();
    case (region)
      0, 1: return CLUSTER_BASE + addr_t'(region) * CLUSTER_STRIDE + ((r % CLUSTER_SIZE) & ~32'h3);
      2:    return L2_BASE + ((r % L2_SIZE) & ~32'h3);
      4:    return DEBUG_BASE + ((r % DEBUG_SIZE) & ~32'h3);
      default: return (r[1:0] == 2'd0) ? 32'h8000_0000 : {4'h2, r[27:2], 2'b00};
    endcase
  endfunction

  function automatic int rr_winner(input int t);
    int k;
    for (int off = 0; off < N_INIT; off++) begin
      k = (ref_ptr[t] + off) % N_INIT;
      if (pending[k] == t) return k;
    end
    return -1;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      n_err++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    if (n_err == err_before) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: %0d mismatches", name, n_err - err_before);
    end
  endtask

  task automatic step_cycle();
    @(negedge clk);
    #1;  // settled well before the next rising edge
  endtask

  // one transaction from initiator i followed along its whole path
  task automatic do_txn(input int i, input addr_t addr, input logic we,
                        input data_t wdata, input string name);
    int    t;
    int    nb;
    logic  rsp_seen;
    data_t exp_rdata;
    t = decode_ref(addr);
    exp_rdata = '0;
    @(negedge clk);
    init_req[i]   = 1'b1;
    init_addr[i]  = addr;
    init_we[i]    = we;
    init_wdata[i] = wdata;
    pending[i]    = t;
    #1;
    while (!init_gnt[i]) step_cycle();
    check({name, " arbitration"}, rr_winner(t), i);
    check({name, " grant while busy"}, 0, busy[t]);
    busy[t]    = 1'b1;
    ref_ptr[t] = (i + 1) % N_INIT;
    pending[i] = -1;
    nb = 0;
    foreach (busy[k]) nb += busy[k];
    if (nb > max_busy) max_busy = nb;
    if (we) ref_mem[t][addr[7:2]] = wdata;
    else exp_rdata = ref_mem[t][addr[7:2]];
    @(negedge clk);
    init_req[i] = 1'b0;  // dropped the cycle after the grant
    #1;
    check({name, " tgt_req"}, 1, tgt_req[t]);
    check({name, " tgt_src"}, i, tgt_src[t]);
    check({name, " tgt_addr"}, addr, tgt_addr[t]);
    check({name, " tgt_we"}, we, tgt_we[t]);
    if (we) check({name, " tgt_wdata"}, wdata, tgt_wdata[t]);
    rsp_seen = 1'b0;
    step_cycle();
    while (!init_rsp_valid[i]) begin
      rsp_seen = tgt_rsp_valid[t] && (tgt_rsp_src[t] == init_idx_t'(i));
      if (rsp_seen) busy[t] = 1'b0;
      step_cycle();
    end
    check({name, " response one cycle after target"}, 1, rsp_seen);
    if (!we) check({name, " rdata"}, exp_rdata, init_rdata[i]);
  endtask

  task automatic run_all(input int n, input string name);
    for (int k = 0; k < N_INIT; k++) begin
      fork
        automatic int kk = k;
        for (int s = 0; s < n; s++) do_txn(kk, st_addr[kk][s], st_we[kk][s], st_data[kk][s], name);
      join_none
    end
    wait fork;
  endtask

  initial begin
    int    e;
    int    i;
    addr_t a;
    data_t d;
    init_req = '0;
    init_we  = '0;
    for (int k = 0; k < N_INIT; k++) begin
      init_addr[k]  = '0;
      init_wdata[k] = '0;
      pending[k]    = -1;
    end
    for (int t = 0; t < N_TGT; t++) begin
      ref_ptr[t] = 0;
      busy[t]    = 1'b0;
      for (int w = 0; w < 64; w++) begin
        ref_mem[t][w] = '0;
      end
    end

    e = n_err;
    repeat (2) @(negedge clk);
    #1;
    check("reset init_gnt", 0, init_gnt);
    check("reset init_rsp_valid", 0, init_rsp_valid);
    check("reset tgt_req", 0, tgt_req);
    wait (rst_n);
    step_cycle();
    check("after reset init_gnt", 0, init_gnt);
    check("after reset init_rsp_valid", 0, init_rsp_valid);
    check("after reset tgt_req", 0, tgt_req);
    report_test("reset", e);

    e = n_err;
    for (int k = 0; k < N_DECODE; k++) begin
      a = rand_addr((k % 4 == 3) ? 4 : k % 4);  // mapped regions only
      i = next_rand() % N_INIT;
      d = next_rand();
      do_txn(i, a, d[0], d, "decode");
    end
    report_test("decode", e);

    e = n_err;
    for (int k = 0; k < N_INIT; k++) do_txn(k, unmapped[k], 1'b0, '0, "default port");
    report_test("default port", e);

    e = n_err;
    for (int k = 0; k < N_DATA; k++) begin
      a = rand_addr(next_rand() % 5);
      d = next_rand();
      i = next_rand() % N_INIT;
      do_txn(i, a, 1'b1, d, "data write");
      i = next_rand() % N_INIT;
      do_txn(i, a, 1'b0, '0, "data read");
    end
    report_test("data path", e);

    // even rounds write one word per initiator and odd rounds read it back
    e = n_err;
    for (int rnd = 0; rnd < N_ROUNDS; rnd++) begin
      if (rnd % 2 == 0) a = rand_addr(next_rand() % 5) & ~32'hFF;
      for (int k = 0; k < N_INIT; k++) begin
        st_addr[k][0] = a + addr_t'(k * 4);
        st_we[k][0]   = (rnd % 2 == 0);
        st_data[k][0] = next_rand();
      end
      run_all(1, "contention");
    end
    report_test("contention", e);

    e = n_err;
    for (int k = 0; k < N_INIT; k++) begin
      for (int s = 0; s < N_STREAM; s++) begin
        st_addr[k][s] = rand_addr((k + s) % 5);  // initiators spread over targets
        st_data[k][s] = next_rand();
        st_we[k][s]   = st_data[k][s][3];
      end
    end
    max_busy = 0;
    run_all(N_STREAM, "concurrency");
    if (max_busy < 2) begin
      n_err++;
      $display("concurrency: never more than one target busy at a time");
    end
    report_test("concurrency", e);

    $display("tests: %0d passed, %0d failed, %0d mismatches", n_pass, n_fail, n_err);
    if (n_fail == 0 && n_err == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog: run still busy after %0d ns, the bus appears to hang", TIMEOUT_NS);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== verif/tb_target_model.sv ====
// behavioral memory targets for the testbench, one 64-word memory per target
// each request is answered after a random 1 to 4 cycles, echoing the source tag
`timescale 1ns/1ps

module tb_target_model import soc_bus_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [N_TGT-1:0]  tgt_req,
  input  addr_t             tgt_addr [N_TGT],
  input  logic [N_TGT-1:0]  tgt_we,
  input  data_t             tgt_wdata [N_TGT],
  input  init_idx_t         tgt_src [N_TGT],
  output logic [N_TGT-1:0]  tgt_rsp_valid,
  output init_idx_t         tgt_rsp_src [N_TGT],
  output data_t             tgt_rdata [N_TGT]
);

  data_t       mem [N_TGT][64];
  int          wait_cnt [N_TGT];    // cycles to the response, 0 when idle
  init_idx_t   src_hold [N_TGT];
  data_t       rdata_hold [N_TGT];
  logic [31:0] lat_state = 32'h5a89;

  function automatic int rand_latency();
    lat_state = lat_state * 32'd1664525 + 32'd1013904223;
    return 1 + int'(lat_state[29:28]);  // upper bits, 1 .. 4
  endfunction

  initial begin
    tgt_rsp_valid = '0;
    for (int t = 0; t < N_TGT; t++) begin
      tgt_rsp_src[t] = '0;
      tgt_rdata[t]   = '0;
      wait_cnt[t]    = 0;
      for (int w = 0; w < 64; w++) begin
        mem[t][w] = '0;
      end
    end
  end

  // responses change on the falling edge, the bus samples them on the rising one
  always @(negedge clk) begin
    for (int t = 0; t < N_TGT; t++) begin
      tgt_rsp_valid[t] = 1'b0;
      if (!rst_n) begin
        wait_cnt[t] = 0;
      end else begin
        if (wait_cnt[t] > 0) begin
          wait_cnt[t]--;
          if (wait_cnt[t] == 0) begin
            tgt_rsp_valid[t] = 1'b1;
            tgt_rsp_src[t]   = src_hold[t];
            tgt_rdata[t]     = rdata_hold[t];
          end
        end
        if (tgt_req[t]) begin
          src_hold[t]   = tgt_src[t];
          rdata_hold[t] = mem[t][tgt_addr[t][7:2]];  // write returns old data
          if (tgt_we[t]) mem[t][tgt_addr[t][7:2]] = tgt_wdata[t];
          wait_cnt[t]   = rand_latency();
        end
      end
    end
  end

endmodule

// ==== verif/tb_clock_gen.sv ====
// testbench clock with a 4 ns period
// synchronous active-low reset held for 5 cycles
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;  // released on a falling edge like all stimulus
  end

endmodule

// ==== rtl/soc_bus.sv ====
// interconnect top: decoder, one target port per target, response router
// four initiators (2 clusters, ext, debug), five targets
// (2 clusters, l2, ext, debug)
`timescale 1ns/1ps

module soc_bus import soc_bus_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  // initiator side
  input  logic [N_INIT-1:0]  init_req,
  input  addr_t              init_addr [N_INIT],
  input  logic [N_INIT-1:0]  init_we,
  input  data_t              init_wdata [N_INIT],
  output logic [N_INIT-1:0]  init_gnt,
  output logic [N_INIT-1:0]  init_rsp_valid,
  output data_t              init_rdata [N_INIT],
  // target side
  output logic [N_TGT-1:0]   tgt_req,
  output addr_t              tgt_addr [N_TGT],
  output logic [N_TGT-1:0]   tgt_we,
  output data_t              tgt_wdata [N_TGT],
  output init_idx_t          tgt_src [N_TGT],
  input  logic [N_TGT-1:0]   tgt_rsp_valid,
  input  init_idx_t          tgt_rsp_src [N_TGT],
  input  data_t              tgt_rdata [N_TGT]
);

  logic [N_INIT-1:0][N_TGT-1:0] sel;      // initiator-major
  logic [N_INIT-1:0][N_TGT-1:0] gnt;
  logic [N_TGT-1:0][N_INIT-1:0] sel_col;  // target-major views
  logic [N_TGT-1:0][N_INIT-1:0] gnt_col;

  req_decoder u_dec (
    .init_req  (init_req),
    .init_addr (init_addr),
    .sel       (sel)
  );

  for (genvar t = 0; t < N_TGT; t++) begin : gen_tgt
    for (genvar i = 0; i < N_INIT; i++) begin : gen_xpose
      assign sel_col[t][i] = sel[i][t];
      assign gnt[i][t]     = gnt_col[t][i];
    end

    target_port u_port (
      .clk           (clk),
      .rst_n         (rst_n),
      .sel_col       (sel_col[t]),
      .init_addr     (init_addr),
      .init_we       (init_we),
      .init_wdata    (init_wdata),
      .tgt_rsp_valid (tgt_rsp_valid[t]),
      .gnt_col       (gnt_col[t]),
      .tgt_req       (tgt_req[t]),
      .tgt_addr      (tgt_addr[t]),
      .tgt_we        (tgt_we[t]),
      .tgt_wdata     (tgt_wdata[t]),
      .tgt_src       (tgt_src[t])
    );
  end

  resp_router u_rsp (
    .clk            (clk),
    .rst_n          (rst_n),
    .gnt            (gnt),
    .tgt_rsp_valid  (tgt_rsp_valid),
    .tgt_rsp_src    (tgt_rsp_src),
    .tgt_rdata      (tgt_rdata),
    .init_gnt       (init_gnt),
    .init_rsp_valid (init_rsp_valid),
    .init_rdata     (init_rdata)
  );

endmodule

// ==== rtl/resp_router.sv ====
// response router: per-initiator grant merge and
// return of target responses by their echoed source index
`timescale 1ns/1ps

module resp_router import soc_bus_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [N_INIT-1:0][N_TGT-1:0]  gnt,
  input  logic [N_TGT-1:0]              tgt_rsp_valid,
  input  init_idx_t                     tgt_rsp_src [N_TGT],
  input  data_t                         tgt_rdata [N_TGT],
  output logic [N_INIT-1:0]             init_gnt,
  output logic [N_INIT-1:0]             init_rsp_valid,
  output data_t                         init_rdata [N_INIT]
);

  logic [N_INIT-1:0][N_TGT-1:0] hit;   // target t answers initiator i
  logic [N_INIT-1:0]            rsp_any;
  data_t                        rdata_mux [N_INIT];

  // at most one target grants a given initiator, plain OR is enough
  always_comb begin
    for (int i = 0; i < N_INIT; i++) begin
      init_gnt[i] = |gnt[i];
    end
  end

  always_comb begin
    for (int i = 0; i < N_INIT; i++) begin
      for (int t = 0; t < N_TGT; t++) begin
        hit[i][t] = tgt_rsp_valid[t] && (tgt_rsp_src[t] == init_idx_t'(i));
      end
    end
  end

  // and-or mux, hit rows are one-hot
  always_comb begin
    for (int i = 0; i < N_INIT; i++) begin
      rsp_any[i]   = |hit[i];
      rdata_mux[i] = '0;
      for (int t = 0; t < N_TGT; t++) begin
        if (hit[i][t]) rdata_mux[i] = rdata_mux[i] | tgt_rdata[t];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) init_rsp_valid <= '0;
    else        init_rsp_valid <= rsp_any;  // one cycle behind the target
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < N_INIT; i++) begin
      if (rsp_any[i]) init_rdata[i] <= rdata_mux[i];
    end
  end

  // one transaction in flight per initiator, so one answer at a time
  for (genvar i = 0; i < N_INIT; i++) begin : gen_chk
    a_single_rsp: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(hit[i]));
  end

endmodule

// ==== rtl/target_port.sv ====
// one target port with a round-robin arbiter over the initiators
// FSM allowing a single open transaction and a registered request stage
`timescale 1ns/1ps

module target_port import soc_bus_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [N_INIT-1:0]  sel_col,          // requesters aimed at this target
  input  addr_t              init_addr [N_INIT],
  input  logic [N_INIT-1:0]  init_we,
  input  data_t              init_wdata [N_INIT],
  input  logic               tgt_rsp_valid,
  output logic [N_INIT-1:0]  gnt_col,
  output logic               tgt_req,
  output addr_t              tgt_addr,
  output logic               tgt_we,
  output data_t              tgt_wdata,
  output init_idx_t          tgt_src
);

  tgt_state_e state, state_next;
  init_idx_t  rr_ptr;      // first initiator looked at
  init_idx_t  win_idx;
  logic       win_found;
  logic       take;        // grant given this cycle

  addr_t      addr_q;
  logic       we_q;
  data_t      wdata_q;
  init_idx_t  src_q;

  // round-robin search starting at rr_ptr
  always_comb begin
    init_idx_t cand;
    win_found = 1'b0;
    win_idx   = '0;
    for (int off = 0; off < N_INIT; off++) begin
      cand = init_idx_t'((int'(rr_ptr) + off) % N_INIT);
      if (!win_found && sel_col[cand]) begin
        win_found = 1'b1;
        win_idx   = cand;
      end
    end
  end

  // grants only while idle so other requests stay held
  assign take = (state == TGT_IDLE) && win_found;

  always_comb begin
    gnt_col = '0;
    if (take) begin
      gnt_col[win_idx] = 1'b1;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      TGT_IDLE:  if (win_found) state_next = TGT_ISSUE;
      TGT_ISSUE: state_next = TGT_WAIT;
      TGT_WAIT:  if (tgt_rsp_valid) state_next = TGT_IDLE;
      default:   state_next = TGT_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= TGT_IDLE;
      rr_ptr <= '0;
    end else begin
      state <= state_next;
      if (take) begin
        rr_ptr <= init_idx_t'((int'(win_idx) + 1) % N_INIT);  // winner goes last
      end
    end
  end

  // payload and source tag captured with the grant
  always_ff @(posedge clk) begin
    if (take) begin
      addr_q  <= init_addr[win_idx];
      we_q    <= init_we[win_idx];
      wdata_q <= init_wdata[win_idx];
      src_q   <= win_idx;
    end
  end

  assign tgt_req   = (state == TGT_ISSUE);  // one cycle after the grant
  assign tgt_addr  = addr_q;
  assign tgt_we    = we_q;
  assign tgt_wdata = wdata_q;
  assign tgt_src   = src_q;

  // target must not answer before it has been asked
  a_rsp_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
    tgt_rsp_valid |-> (state == TGT_WAIT));

endmodule

// ==== rtl/req_decoder.sv ====
// request decoder mapping every initiator address onto one target
// unmatched addresses fall through to the external port
`timescale 1ns/1ps

module req_decoder import soc_bus_pkg::*; (
  input  logic [N_INIT-1:0]             init_req,
  input  addr_t                         init_addr [N_INIT],
  output logic [N_INIT-1:0][N_TGT-1:0]  sel
);

  // half-open range check that cannot wrap at base + size
  function automatic logic in_range(input addr_t addr, input addr_t base,
                                    input addr_t size);
    return (addr >= base) && ((addr - base) < size);
  endfunction

  function automatic tgt_idx_t decode_addr(input addr_t addr);
    tgt_idx_t dst;
    addr_t    cl_base;
    dst = IDX_EXT;  // default port
    for (int c = 0; c < N_CLUSTERS; c++) begin
      cl_base = CLUSTER_BASE + addr_t'(c) * CLUSTER_STRIDE;
      if (in_range(addr, cl_base, CLUSTER_SIZE)) begin
        dst = tgt_idx_t'(c);
      end
    end
    if (in_range(addr, L2_BASE, L2_SIZE)) begin
      dst = IDX_L2;
    end
    if (in_range(addr, DEBUG_BASE, DEBUG_SIZE)) begin
      dst = IDX_DEBUG;
    end
    return dst;
  endfunction

  // one bit per requesting initiator
  always_comb begin
    sel = '0;  // rows of idle initiators stay zero
    for (int i = 0; i < N_INIT; i++) begin
      if (init_req[i]) begin
        sel[i][decode_addr(init_addr[i])] = 1'b1;
      end
    end
  end

endmodule

// ==== rtl/soc_bus_pkg.sv ====
// interconnect widths, counts and target indices
// fixed address map of clusters, L2 and debug module
// address, data and index types, target port FSM states
package soc_bus_pkg;

  // initiator and target counts
  localparam int unsigned N_CLUSTERS = 2;
  localparam int unsigned N_INIT     = N_CLUSTERS + 2;  // clusters, ext, debug
  localparam int unsigned N_TGT      = N_CLUSTERS + 3;  // clusters, l2, ext, debug

  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned INIT_IDX_W = $clog2(N_INIT);
  localparam int unsigned TGT_IDX_W  = $clog2(N_TGT);

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [INIT_IDX_W-1:0] init_idx_t;  // source tag added at the target side
  typedef logic [TGT_IDX_W-1:0]  tgt_idx_t;

  // target indices, clusters sit at 0 .. N_CLUSTERS-1
  localparam tgt_idx_t IDX_L2    = tgt_idx_t'(N_CLUSTERS);
  localparam tgt_idx_t IDX_EXT   = tgt_idx_t'(N_CLUSTERS + 1);  // also the default port
  localparam tgt_idx_t IDX_DEBUG = tgt_idx_t'(N_CLUSTERS + 2);

  // cluster i covers [base + i*stride, base + i*stride + size)
  localparam addr_t CLUSTER_BASE   = 32'h1000_0000;
  localparam addr_t CLUSTER_STRIDE = 32'h0040_0000;
  localparam addr_t CLUSTER_SIZE   = 32'h0030_0000;

  localparam addr_t L2_BASE    = 32'h1C00_0000;
  localparam addr_t L2_SIZE    = 32'h0001_0000;  // single L2 port

  localparam addr_t DEBUG_BASE = 32'h1A11_0000;
  localparam addr_t DEBUG_SIZE = 32'h0000_1000;

  // target port FSM
  typedef enum logic [1:0] {
    TGT_IDLE,   // free, may grant
    TGT_ISSUE,  // request pulse toward the target
    TGT_WAIT    // waiting for the single response
  } tgt_state_e;

endpackage
